/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_jy_mapper
FILELIST  := project.f
OBJDIR    := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* project.f */
source/jy_pkg.sv
source/jy_bank_if.sv
source/jy_multiplier.sv
source/jy_irq_counter.sv
source/jy_addr_map.sv
source/jy_cpu_regs.sv
source/jy_mapper_top.sv
verification/tb_jy_mapper.sv

/* source/jy_addr_map.sv */
// JY mapper PRG and CHR bank translation with nametable mirroring
`timescale 1ns/1ps

module jy_addr_map import jy_pkg::*; #(
	parameter bit RAM_SUPPORT = 1'b1,
	parameter bit CHR_RAM     = 1'b0
) (
	input  addr_cpu_t   prg_ain,
	input  logic        prg_write,
	input  logic [13:0] chr_ain,
	input  logic        chr_read,
	jy_bank_if.map      bank,
	output logic [21:0] prg_aout,
	output logic        prg_allow,
	output logic [21:0] chr_aout,
	output logic        chr_allow,
	output logic        vram_a10,
	output logic        vram_ce
);

	prg_mode_e  prg_mode;
	chr_mode_e  chr_mode;
	logic       prg_6xxx;
	logic       prg_ram;
	logic [1:0] prg_slot;
	logic [6:0] bank_val;
	logic [5:0] bank_order;
	logic [5:0] prg_page;
	logic [2:0] chr_slot;
	logic [8:0] chr_val;
	logic [8:0] chr_sel;

	assign prg_mode = prg_mode_e'(bank.bank_mode[1:0]);
	assign chr_mode = chr_mode_e'(bank.bank_mode[4:3]);
	assign prg_6xxx = prg_ain[15:13] == 3'b011;
	assign prg_ram  = prg_6xxx & ~bank.bank_mode[7];

	// $6000 ROM window has A14-13 set and so lands on register 3
	always_comb begin
		if (prg_mode == PRG_32K)
			prg_slot = 2'd3;
		else if (prg_mode == PRG_16K)
			prg_slot = {prg_ain[14], 1'b1};
		else
			prg_slot = prg_ain[14:13];
	end

	assign bank_val = (!bank.bank_mode[2] && prg_slot == 2'd3) ? 7'h7F :
	                  bank.prg_bank[prg_slot][6:0];
	// Reversed 7-bit number, top bit never reaches the page
	assign bank_order = (prg_mode == PRG_8K_REV) ?
	                    {bank_val[1], bank_val[2], bank_val[3], bank_val[4], bank_val[5],
	                     bank_val[6]} : bank_val[5:0];

	always_comb begin
		case (prg_mode)
			PRG_32K: prg_page = {bank_order[3:0], prg_ain[14:13]};
			PRG_16K: prg_page = {bank_order[4:0], prg_ain[13]};
			default: prg_page = bank_order;
		endcase
	end

	assign prg_aout  = (prg_ram && RAM_SUPPORT) ? {9'h01E, prg_ain[12:0]} : // $3C000 base
	                   {1'b0, bank.outer_bank[2:1], prg_page, prg_ain[12:0]};
	assign prg_allow = (prg_ain >= 16'h6000) && (prg_ram ? RAM_SUPPORT : !prg_write);

	always_comb begin
		case (chr_mode)
			CHR_8K: chr_slot = 3'd0;
			CHR_4K: chr_slot = {chr_ain[12], 2'b00};
			CHR_2K: chr_slot = {chr_ain[12:11], 1'b0};
			default: chr_slot = chr_ain[12:10];
		endcase
	end

	assign chr_val = bank.chr_bank[chr_slot][8:0];

	always_comb begin
		case (chr_mode)
			CHR_8K: chr_sel = {chr_val[5:0], chr_ain[12:10]};
			CHR_4K: chr_sel = {chr_val[6:0], chr_ain[11:10]};
			CHR_2K: chr_sel = {chr_val[7:0], chr_ain[10]};
			default: chr_sel = chr_val;
		endcase
	end

	assign chr_aout = {2'b10, bank.outer_bank[3],
	                   bank.outer_bank[5] ? chr_sel[8] : bank.outer_bank[0],
	                   chr_sel[7:0], chr_ain[9:0]};

	// Write window for CHR-RAM, reads never need it
	assign chr_allow = CHR_RAM & bank.ppu_conf[6] & ~chr_read;

	always_comb begin
		case (bank.mirroring[1:0])
			2'd0: vram_a10 = chr_ain[10]; // Vertical
			2'd1: vram_a10 = chr_ain[11]; // Horizontal
			2'd2: vram_a10 = 1'b0;
			default: vram_a10 = 1'b1;
		endcase
	end

	assign vram_ce = chr_ain[13];

endmodule

/* source/jy_bank_if.sv */
// Banking configuration bus between the JY register block and the address mapper
`timescale 1ns/1ps

interface jy_bank_if import jy_pkg::*; ();

	byte_t           bank_mode;  // PRG/CHR modes, fixed last bank, RAM select
	prg_bank_t [3:0] prg_bank;
	chr_bank_t [7:0] chr_bank;
	byte_t           outer_bank; // Upper PRG and CHR address bits
	logic [3:0]      mirroring;
	byte_t           ppu_conf;   // Bit 6 opens CHR-RAM writes

	modport regs (output bank_mode, prg_bank, chr_bank, outer_bank, mirroring, ppu_conf);

	modport map (input bank_mode, prg_bank, chr_bank, outer_bank, mirroring, ppu_conf);

endinterface

/* source/jy_cpu_regs.sv */
// JY mapper CPU register file with write decoding and read-back multiplexer
`timescale 1ns/1ps

module jy_cpu_regs import jy_pkg::*; #(
	parameter logic [1:0] DIP = 2'b00
) (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         enable,
	input  logic         ce,
	input  addr_cpu_t    prg_ain,
	input  logic         prg_write,
	input  byte_t        prg_din,
	jy_bank_if.regs      bank,
	output logic         mul_start,
	output byte_t        mul_a,
	output byte_t        mul_b,
	input  logic [15:0]  product,
	output logic         irq_wr,
	output irq_reg_e     irq_sel,
	output byte_t        irq_wdata,
	output byte_t        prg_dout,
	output logic         prg_dout_valid
);

	byte_t acc;
	byte_t acc_test;
	logic  cpu_wr;

	assign cpu_wr = enable & ce & prg_write; // M2-qualified CPU write

	// IRQ block sees the write on the same clock
	assign irq_wr    = cpu_wr && (prg_ain[15:3] == 13'h1800) && (prg_ain[2:0] != 3'b111);
	assign irq_sel   = irq_reg_e'(prg_ain[2:0]);
	assign irq_wdata = prg_din;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bank.bank_mode  <= '0;
			bank.prg_bank   <= '0;
			bank.chr_bank   <= '0;
			bank.outer_bank <= '0;
			bank.mirroring  <= '0;
			bank.ppu_conf   <= '0;
			mul_start       <= 1'b0;
			mul_a           <= '0;
			mul_b           <= '0;
			acc             <= '0;
			acc_test        <= '0;
		end else begin
			mul_start <= 1'b0;
			if (!enable) begin
				bank.bank_mode[2] <= 1'b0; // Force last PRG bank to $FF
			end else if (cpu_wr) begin
				casez (prg_ain)
					REG_MUL_A: begin
						mul_a     <= prg_din;
						mul_start <= 1'b1;
					end
					REG_MUL_B: begin
						mul_b     <= prg_din;
						mul_start <= 1'b1;
					end
					REG_ACC_ADD: acc <= acc + prg_din; // Wraps at 256
					REG_ACC_TEST: begin
						acc      <= '0;
						acc_test <= prg_din;
					end
					16'b1000_0000_0000_00??: bank.prg_bank[prg_ain[1:0]] <= prg_din;
					16'b1001_0000_0000_0???: bank.chr_bank[prg_ain[2:0]][7:0] <= prg_din;
					16'b1010_0000_0000_0???: bank.chr_bank[prg_ain[2:0]][15:8] <= prg_din;
					16'b1101_0000_0000_00??: begin
						case (prg_ain[1:0])
							2'd0: bank.bank_mode  <= prg_din;
							2'd1: bank.mirroring  <= prg_din[3:0];
							2'd2: bank.ppu_conf   <= prg_din;
							default: bank.outer_bank <= prg_din;
						endcase
					end
					default: ; // IRQ writes go out on irq_wr
				endcase
			end
		end
	end

	// Read-back, open bus elsewhere
	always_comb begin
		prg_dout       = 8'hFF;
		prg_dout_valid = 1'b1;
		case (prg_ain)
			REG_DIP0, REG_DIP1: prg_dout = {DIP, 6'b00_0000};
			REG_MUL_A:          prg_dout = product[7:0];
			REG_MUL_B:          prg_dout = product[15:8];
			REG_ACC_ADD:        prg_dout = acc;
			REG_ACC_TEST:       prg_dout = acc_test;
			default:            prg_dout_valid = 1'b0;
		endcase
	end

endmodule

/* source/jy_irq_counter.sv */
// JY mapper IRQ prescaler and counter with selectable clock source
`timescale 1ns/1ps

module jy_irq_counter import jy_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        ce,
	input  logic        prg_write,
	input  logic [13:0] chr_ain,
	input  logic        chr_read,
	input  logic        wr,
	input  irq_reg_e    sel,
	input  byte_t       wdata,
	output logic        irq
);

	byte_t    mode;
	byte_t    xor_mask;
	byte_t    prescaler;
	byte_t    count;
	logic     enabled;
	logic     pending;
	logic     a12_prev;
	irq_src_e src;
	logic     src_evt;
	logic     count_up;
	logic     step;
	logic     pre_wrap;
	logic     cnt_wrap;

	assign src      = irq_src_e'(mode[1:0]);
	assign count_up = mode[6];
	assign step     = src_evt & enabled & (mode[7] ^ mode[6]); // Halted when 7 and 6 match

	always_comb begin
		case (src)
			SRC_M2:        src_evt = ce;
			SRC_A12_RISE:  src_evt = chr_ain[12] & ~a12_prev;
			SRC_PPU_READ:  src_evt = chr_read;
			SRC_CPU_WRITE: src_evt = ce & prg_write;
			default:       src_evt = 1'b0;
		endcase
	end

	// Terminal values, 3-bit or 8-bit prescaler
	assign pre_wrap = mode[2] ? (prescaler[2:0] == (count_up ? 3'h7 : 3'h0)) :
	                            (prescaler == (count_up ? 8'hFF : 8'h00));
	assign cnt_wrap = count == (count_up ? 8'hFF : 8'h00);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mode      <= '0;
			xor_mask  <= '0;
			prescaler <= '0;
			count     <= '0;
			enabled   <= 1'b0;
			pending   <= 1'b0;
			a12_prev  <= 1'b0;
		end else begin
			a12_prev <= chr_ain[12];
			if (step) begin
				prescaler <= count_up ? prescaler + 8'd1 : prescaler - 8'd1;
				if (pre_wrap) begin
					count <= count_up ? count + 8'd1 : count - 8'd1;
					if (cnt_wrap)
						pending <= 1'b1;
				end
			end
			// CPU writes take priority over counting
			if (wr) begin
				case (sel)
					IRQ_CTRL: begin
						enabled <= wdata[0];
						if (!wdata[0]) begin
							pending   <= 1'b0;
							prescaler <= '0;
						end
					end
					IRQ_MODE:     mode <= wdata;
					IRQ_DISABLE: begin
						enabled   <= 1'b0;
						pending   <= 1'b0; // Acknowledge
						prescaler <= '0;
					end
					IRQ_ENABLE:   enabled <= 1'b1;
					IRQ_PRESCALE: prescaler <= wdata ^ xor_mask;
					IRQ_COUNT:    count <= wdata ^ xor_mask;
					IRQ_XOR:      xor_mask <= wdata;
					default: ;
				endcase
			end
		end
	end

	assign irq = pending & enabled;

endmodule

/* source/jy_mapper_top.sv */
// JY mapper core top level joining registers, multiplier, IRQ and address mapping
`timescale 1ns/1ps

module jy_mapper_top import jy_pkg::*; #(
	parameter bit         RAM_SUPPORT = 1'b1,
	parameter bit         CHR_RAM     = 1'b0,
	parameter logic [1:0] DIP         = 2'b00
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        enable,
	input  logic        ce,          // M2 pulse
	input  addr_cpu_t   prg_ain,
	input  logic        prg_write,
	input  byte_t       prg_din,
	output byte_t       prg_dout,
	output logic        prg_dout_valid,
	output logic [21:0] prg_aout,
	output logic        prg_allow,
	input  logic [13:0] chr_ain,
	input  logic        chr_read,
	output logic [21:0] chr_aout,
	output logic        chr_allow,
	output logic        vram_a10,
	output logic        vram_ce,
	output logic        irq
);

	logic        mul_start;
	byte_t       mul_a;
	byte_t       mul_b;
	logic [15:0] product;
	logic        irq_wr;
	irq_reg_e    irq_sel;
	byte_t       irq_wdata;

	jy_bank_if bank_bus ();

	jy_cpu_regs #(
		.DIP(DIP)
	) i_regs (
		.clk(clk),
		.arst_n(arst_n),
		.enable(enable),
		.ce(ce),
		.prg_ain(prg_ain),
		.prg_write(prg_write),
		.prg_din(prg_din),
		.bank(bank_bus.regs),
		.mul_start(mul_start),
		.mul_a(mul_a),
		.mul_b(mul_b),
		.product(product),
		.irq_wr(irq_wr),
		.irq_sel(irq_sel),
		.irq_wdata(irq_wdata),
		.prg_dout(prg_dout),
		.prg_dout_valid(prg_dout_valid)
	);

	jy_multiplier i_mul (
		.clk(clk),
		.arst_n(arst_n),
		.start(mul_start),
		.a(mul_a),
		.b(mul_b),
		.product(product)
	);

	jy_irq_counter i_irq (
		.clk(clk),
		.arst_n(arst_n),
		.ce(ce),
		.prg_write(prg_write),
		.chr_ain(chr_ain),
		.chr_read(chr_read),
		.wr(irq_wr),
		.sel(irq_sel),
		.wdata(irq_wdata),
		.irq(irq)
	);

	jy_addr_map #(
		.RAM_SUPPORT(RAM_SUPPORT),
		.CHR_RAM(CHR_RAM)
	) i_map (
		.prg_ain(prg_ain),
		.prg_write(prg_write),
		.chr_ain(chr_ain),
		.chr_read(chr_read),
		.bank(bank_bus.map),
		.prg_aout(prg_aout),
		.prg_allow(prg_allow),
		.chr_aout(chr_aout),
		.chr_allow(chr_allow),
		.vram_a10(vram_a10),
		.vram_ce(vram_ce)
	);

endmodule

/* source/jy_multiplier.sv */
// Serial 8x8 shift-add multiplier, one bit of b per clock
`timescale 1ns/1ps

module jy_multiplier import jy_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        start,
	input  byte_t       a,
	input  byte_t       b,
	output logic [15:0] product
);

	logic [15:0] shift_a;  // Multiplicand aligned to the current bit
	logic [7:0]  bit_sel;  // One-hot pointer into b, zero when done

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			shift_a <= '0;
			bit_sel <= '0;
			product <= '0;
		end else if (start) begin
			product <= {8'h00, b[0] ? a : 8'h00}; // Bit 0 partial product
			shift_a <= {7'b000_0000, a, 1'b0};
			bit_sel <= 8'b0000_0010;
		end else if (bit_sel != 8'h00) begin
			if ((bit_sel & b) != 8'h00)
				product <= product + shift_a;
			shift_a <= shift_a << 1;
			bit_sel <= bit_sel << 1; // Bit 7 shifts out and stops
		end
	end

endmodule

/* source/jy_pkg.sv */
// JY mapper shared types, CPU register addresses and mode encodings
package jy_pkg;

	typedef logic [15:0] addr_cpu_t; // CPU address bus
	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  prg_bank_t; // 8 KB PRG bank number
	typedef logic [15:0] chr_bank_t; // CHR bank, low and high byte

	// Arithmetic unit and DIP window
	localparam addr_cpu_t REG_MUL_A    = 16'h5800; // Multiplicand, product low on read
	localparam addr_cpu_t REG_MUL_B    = 16'h5801; // Multiplier, product high on read
	localparam addr_cpu_t REG_ACC_ADD  = 16'h5802; // Accumulate
	localparam addr_cpu_t REG_ACC_TEST = 16'h5803; // Clear accumulator, test byte
	localparam addr_cpu_t REG_DIP0     = 16'h5000;
	localparam addr_cpu_t REG_DIP1     = 16'h5400;

	// IRQ registers $C000-$C006, indexed by A2-A0
	typedef enum logic [2:0] {
		IRQ_CTRL     = 3'd0,
		IRQ_MODE     = 3'd1,
		IRQ_DISABLE  = 3'd2,
		IRQ_ENABLE   = 3'd3,
		IRQ_PRESCALE = 3'd4,
		IRQ_COUNT    = 3'd5,
		IRQ_XOR      = 3'd6
	} irq_reg_e;

	typedef enum logic [1:0] {
		SRC_M2        = 2'd0, // Every CPU cycle
		SRC_A12_RISE  = 2'd1, // PPU A12 low to high
		SRC_PPU_READ  = 2'd2,
		SRC_CPU_WRITE = 2'd3
	} irq_src_e;

	// bank_mode[1:0]
	typedef enum logic [1:0] {
		PRG_32K    = 2'd0,
		PRG_16K    = 2'd1,
		PRG_8K     = 2'd2,
		PRG_8K_REV = 2'd3 // 8 KB with bit-reversed bank numbers
	} prg_mode_e;

	// bank_mode[4:3]
	typedef enum logic [1:0] {
		CHR_8K = 2'd0,
		CHR_4K = 2'd1,
		CHR_2K = 2'd2,
		CHR_1K = 2'd3
	} chr_mode_e;

endpackage

/* verification/jy_stimulus.txt */
# W addr data | R addr data valid | P addr write prg_aout prg_allow
# C chr_addr chr_aout vram_a10 | I pulses irq   (all fields hex)
I 0 0
R 1234 FF 0
R 5000 80 1
R 5400 80 1
# Multiplier
W 5800 FF
W 5801 FF
R 5800 01 1
R 5801 FE 1
W 5800 0D
W 5801 0B
R 5800 8F 1
R 5801 00 1
W 5800 A5
W 5801 3C
R 5800 AC 1
R 5801 26 1
W 5801 00
R 5800 00 1
R 5801 00 1
# Accumulator and test register
W 5802 10
W 5802 F5
W 5802 3C
R 5802 41 1
W 5803 5A
R 5802 00 1
R 5803 5A 1
# PRG banking
W 8000 01
W 8001 22
W 8002 13
W 8003 0C
P 8000 0 078000 1
P E123 0 07E123 1
W D000 04
P A456 0 062456 1
W D000 05
P 8000 0 008000 1
P E001 0 032001 1
W D000 01
P C000 0 07C000 1
W D000 06
P A010 0 044010 1
P FFFF 0 019FFF 1
W D000 07
P C000 0 048000 1
P E000 0 030000 1
W D003 06
P E000 0 1B0000 1
W D003 00
P 6000 0 03C000 1
P 7ABC 1 03DABC 1
P 8000 1 000000 0
P 4020 0 048020 0
# CHR banking
W 9000 05
W 9001 11
W 9002 22
W 9003 33
W 9004 44
W 9006 66
W 9007 77
W A007 01
W D000 00
C 1C05 20BC05 1
W D000 08
C 0800 205800 0
C 1400 204400 1
W D000 10
C 1A3F 23323F 0
W D000 18
C 1C00 21DC00 1
W D003 20
C 1C00 25DC00 1
W D003 09
C 0400 2C4400 1
W D003 00
# Mirroring
W D001 01
C 2800 208800 1
C 2400 204400 0
W D001 02
C 2C00 20CC00 0
W D001 03
C 2000 201400 1
# IRQ on M2, up count, 3-bit prescaler
W C002 00
W C006 00
W C001 44
W C004 00
W C005 FE
W C003 00
I 0F 0
I 01 1
W C002 00
I 00 0

/* verification/tb_jy_mapper.sv */
// Testbench for the JY mapper core, driven by a command file with expected values
`timescale 1ns/1ps

module tb_jy_mapper;

	localparam int CLK_HALF    = 2;
	localparam int MUL_WAIT    = 12; // Serial multiply settles within 9
	localparam int IRQ_TIMEOUT = 20;
	localparam bit CHR_RAM     = 1'b1;

	logic        clk;
	logic        arst_n;
	logic        enable;
	logic        ce;
	logic [15:0] prg_ain;
	logic        prg_write;
	logic [7:0]  prg_din;
	logic [7:0]  prg_dout;
	logic        prg_dout_valid;
	logic [21:0] prg_aout;
	logic        prg_allow;
	logic [13:0] chr_ain;
	logic        chr_read;
	logic [21:0] chr_aout;
	logic        chr_allow;
	logic        vram_a10;
	logic        vram_ce;
	logic        irq;

	logic [7:0]  mul_a_ref; // Operands last written on the CPU bus
	logic [7:0]  mul_b_ref;
	logic [7:0]  ppu_conf_ref; // Last byte written to $D002

	jy_mapper_top #(
		.RAM_SUPPORT(1'b1),
		.CHR_RAM(CHR_RAM),
		.DIP(2'b10)
	) i_dut (
		.clk(clk),
		.arst_n(arst_n),
		.enable(enable),
		.ce(ce),
		.prg_ain(prg_ain),
		.prg_write(prg_write),
		.prg_din(prg_din),
		.prg_dout(prg_dout),
		.prg_dout_valid(prg_dout_valid),
		.prg_aout(prg_aout),
		.prg_allow(prg_allow),
		.chr_ain(chr_ain),
		.chr_read(chr_read),
		.chr_aout(chr_aout),
		.chr_allow(chr_allow),
		.vram_a10(vram_a10),
		.vram_ce(vram_ce),
		.irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERR t=%0d ns %s: got %0h, expected %0h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	task automatic expect_fields(input int got, input int want);
		if (got != want) begin
			$display("Malformed line in the stimulus file, %0d of %0d fields read", got, want);
			abort_run();
		end
	endtask

	// One M2-qualified CPU write, then idle while a multiply runs
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		prg_ain   = addr;
		prg_din   = data;
		prg_write = 1'b1;
		ce        = 1'b1;
		@(posedge clk);
		#1;
		ce        = 1'b0;
		prg_write = 1'b0;
		if (addr == 16'h5800)
			mul_a_ref = data;
		if (addr == 16'h5801)
			mul_b_ref = data;
		if (addr == 16'hD002)
			ppu_conf_ref = data;
		if (addr == 16'h5800 || addr == 16'h5801) begin
			repeat (MUL_WAIT) @(posedge clk);
			#1;
		end
	endtask

	task automatic cpu_read(input logic [15:0] addr, input logic [31:0] exp_data,
		input logic [31:0] exp_valid);
		logic [15:0] prod_ref;
		prod_ref  = 16'(mul_a_ref) * 16'(mul_b_ref);
		prg_ain   = addr;
		prg_write = 1'b0;
		@(negedge clk); // Read mux is combinational
		check_value("prg_dout", 32'(prg_dout), exp_data);
		check_value("prg_dout_valid", 32'(prg_dout_valid), exp_valid);
		if (addr == 16'h5800)
			check_value("product low", 32'(prg_dout), 32'(prod_ref[7:0]));
		if (addr == 16'h5801)
			check_value("product high", 32'(prg_dout), 32'(prod_ref[15:8]));
		@(posedge clk);
		#1;
	endtask

	task automatic prg_check(input logic [15:0] addr, input logic wr,
		input logic [31:0] exp_aout, input logic [31:0] exp_allow);
		prg_ain   = addr;
		prg_write = wr; // No ce, so no register write
		@(negedge clk);
		check_value("prg_aout", 32'(prg_aout), exp_aout);
		check_value("prg_allow", 32'(prg_allow), exp_allow);
		@(posedge clk);
		#1;
		prg_write = 1'b0;
	endtask

	// Nametable select is A13, CHR-RAM window opens with ppu_conf bit 6
	task automatic chr_check(input logic [13:0] addr, input logic [31:0] exp_aout,
		input logic [31:0] exp_a10);
		chr_ain = addr;
		@(negedge clk);
		check_value("chr_aout", 32'(chr_aout), exp_aout);
		check_value("vram_a10", 32'(vram_a10), exp_a10);
		check_value("vram_ce", 32'(vram_ce), 32'(addr[13]));
		check_value("chr_allow", 32'(chr_allow), 32'(CHR_RAM & ppu_conf_ref[6]));
		@(posedge clk);
		#1;
	endtask

	// M2 pulses with no bus write, irq must hold low until the last one
	task automatic irq_pulses(input int count, input logic exp_irq);
		int waited;
		for (int i = 0; i < count; i++) begin
			ce = 1'b1;
			@(posedge clk);
			#1;
			ce = 1'b0;
			@(posedge clk);
			#1;
			if (!exp_irq || i < count - 1)
				check_value("irq", 32'(irq), 32'(0));
		end
		if (exp_irq) begin
			waited = 0;
			while (irq !== 1'b1 && waited < IRQ_TIMEOUT) begin
				@(posedge clk);
				#1;
				waited++;
			end
			if (irq !== 1'b1) begin
				$display("Timed out waiting for irq to go high");
				abort_run();
			end
		end else begin
			check_value("irq", 32'(irq), 32'(0));
		end
	endtask

	initial begin
		int               fd;
		int               n;
		int               cmds;
		logic             done;
		logic [7:0]       cmd;
		logic [31:0]      f1;
		logic [31:0]      f2;
		logic [31:0]      f3;
		logic [31:0]      f4;
		logic [8*160-1:0] line;

		arst_n       = 1'b0;
		enable       = 1'b1;
		ce           = 1'b0;
		prg_ain      = '0;
		prg_write    = 1'b0;
		prg_din      = '0;
		chr_ain      = '0;
		chr_read     = 1'b0;
		mul_a_ref    = '0;
		mul_b_ref    = '0;
		ppu_conf_ref = '0;
		cmds         = 0;
		done         = 1'b0;

		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;

		fd = $fopen("verification/jy_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file");
			abort_run();
		end

		while (!done) begin
			n = $fscanf(fd, " %c", cmd);
			if (n != 1) begin
				done = 1'b1; // End of file
			end else begin
				case (cmd)
					"#": n = $fgets(line, fd); // Comment line
					"W": begin
						n = $fscanf(fd, "%h %h", f1, f2);
						expect_fields(n, 2);
						cpu_write(f1[15:0], f2[7:0]);
					end
					"R": begin
						n = $fscanf(fd, "%h %h %h", f1, f2, f3);
						expect_fields(n, 3);
						cpu_read(f1[15:0], f2, f3);
					end
					"P": begin
						n = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
						expect_fields(n, 4);
						prg_check(f1[15:0], f2[0], f3, f4);
					end
					"C": begin
						n = $fscanf(fd, "%h %h %h", f1, f2, f3);
						expect_fields(n, 3);
						chr_check(f1[13:0], f2, f3);
					end
					"I": begin
						n = $fscanf(fd, "%h %h", f1, f2);
						expect_fields(n, 2);
						irq_pulses(int'(f1), f2[0]);
					end
					default: begin
						$display("Unknown command in the stimulus file");
						abort_run();
					end
				endcase
				if (cmd != "#")
					cmds++;
			end
		end
		$fclose(fd);
		$display("Ran %0d commands", cmds);
		$display("Everything OK");
		$finish;
	end

endmodule
